//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address width
`define CPU_XLEN 32

// Register number width, 32 registers
`define CPU_REG_AW 5

// First fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// Word loaded into IF/ID on a flush
`define CPU_NOP_WORD 32'h0000_0000

`endif

//--- common/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // Kept opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Kept R-type functions
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    ////////////////////
    // Instruction formats
    ////////////////////

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] index;
    } j_fmt_t;

    // One fetched word seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    ////////////////////
    // Pipeline payloads
    ////////////////////

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t  pc4;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     imm;
        word_t     pc4;
    } dec_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t dest;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

endpackage

//--- execute/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t  a,
    input  cpu_pkg::word_t  b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t  result,
    output logic            zero
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            // Signed compare
            cpu_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            // Immediate into the upper half
            cpu_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               stall,
    input  logic               flush,
    input  cpu_pkg::dec_t      dec,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    input  cpu_pkg::reg_wr_t   wb,
    output cpu_pkg::ex_mem_t   ex_mem,
    output cpu_pkg::reg_addr_t ex_dest,
    output logic               ex_mem_read,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target
);

    cpu_pkg::dec_t  idex;
    cpu_pkg::word_t idex_rs_data;
    cpu_pkg::word_t idex_rt_data;
    cpu_pkg::word_t op_a;
    cpu_pkg::word_t fwd_rt;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_result;
    logic           alu_zero;

    ////////////////////
    // ID/EX register
    ////////////////////

    // A bubble is the all-zero control word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex <= '0;
        end else if (stall || flush) begin
            idex <= '0;
        end else begin
            idex <= dec;
        end
    end

    always_ff @(posedge clk) begin
        idex_rs_data <= rs_data;
        idex_rt_data <= rt_data;
    end

    assign ex_dest     = idex.dest;
    assign ex_mem_read = idex.ctrl.mem_read;

    ////////////////////
    // Forwarding
    ////////////////////

    // EX/MEM wins over MEM/WB; loads in EX/MEM are covered by the stall
    function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_addr_t src,
                                               input cpu_pkg::word_t     reg_val);
        if (src != '0 && ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
            ex_mem.dest == src) begin
            return ex_mem.result;
        end else if (src != '0 && wb.en && wb.addr == src) begin
            return wb.data;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a   = forward(idex.rs, idex_rs_data);
        fwd_rt = forward(idex.rt, idex_rt_data);
        op_b   = idex.ctrl.use_imm ? idex.imm : fwd_rt;
    end

    alu inst_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (idex.ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // bne takes the branch when the difference is non-zero
    assign branch_taken  = idex.ctrl.branch && (alu_zero != idex.ctrl.branch_ne);
    assign branch_target = idex.pc4 + {idex.imm[29:0], 2'b00};

    ////////////////////
    // EX/MEM register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= idex.ctrl.reg_write | idex.ctrl.mem_read |
                                 idex.ctrl.mem_write;
            ex_mem.reg_write  <= idex.ctrl.reg_write;
            ex_mem.mem_read   <= idex.ctrl.mem_read;
            ex_mem.mem_write  <= idex.ctrl.mem_write;
            ex_mem.dest       <= idex.dest;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= fwd_rt;
        end
    end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_wr_t   wr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);

    cpu_pkg::word_t regs [2**`CPU_REG_AW];

    // Same-cycle write is passed through to the reader
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr.en && wr.addr == addr) begin
            return wr.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::if_id_t if_id,
    output cpu_pkg::dec_t   dec,
    output logic            id_jump
);

    cpu_pkg::instr_u instr;
    logic            zero_ext;

    assign instr   = if_id.instr;
    assign id_jump = dec.ctrl.jump;

    always_comb begin
        dec      = '0;
        zero_ext = 1'b0;
        dec.rs   = instr.i.rs;
        dec.rt   = instr.i.rt;
        dec.pc4  = if_id.pc4;
        case (instr.r.opcode)
            cpu_pkg::OP_RTYPE: begin
                dec.ctrl.reg_write = 1'b1;
                dec.dest           = instr.r.rd;
                case (instr.r.funct)
                    cpu_pkg::FN_ADD: dec.ctrl.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: dec.ctrl.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: dec.ctrl.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  dec.ctrl.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: dec.ctrl.alu_op = cpu_pkg::ALU_SLT;
                    // All-zero nop lands here too
                    default: begin
                        dec.ctrl.reg_write = 1'b0;
                        dec.dest           = '0;
                    end
                endcase
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_LUI,
            cpu_pkg::OP_LW: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.mem_read  = (instr.i.opcode == cpu_pkg::OP_LW);
                dec.dest           = instr.i.rt;
                case (instr.i.opcode)
                    cpu_pkg::OP_ANDI: dec.ctrl.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::OP_ORI:  dec.ctrl.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::OP_LUI:  dec.ctrl.alu_op = cpu_pkg::ALU_LUI;
                    default:          dec.ctrl.alu_op = cpu_pkg::ALU_ADD;
                endcase
                // Logic immediates are zero extended
                zero_ext = (instr.i.opcode == cpu_pkg::OP_ANDI) ||
                           (instr.i.opcode == cpu_pkg::OP_ORI) ||
                           (instr.i.opcode == cpu_pkg::OP_LUI);
            end
            cpu_pkg::OP_SW: begin
                dec.ctrl.mem_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                // Compared through a subtract and the zero flag
                dec.ctrl.branch    = 1'b1;
                dec.ctrl.branch_ne = (instr.i.opcode == cpu_pkg::OP_BNE);
                dec.ctrl.alu_op    = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OP_J: begin
                dec.ctrl.jump = 1'b1;
            end
            default: begin
                dec.ctrl = '0;
            end
        endcase
        dec.imm = zero_ext ? {16'h0000, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            flush,
    input  logic [1:0]      pc_sel,
    input  cpu_pkg::word_t  branch_target,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::word_t  imem_addr,
    output cpu_pkg::if_id_t if_id
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc4;
    cpu_pkg::word_t jump_target;
    cpu_pkg::word_t pc_next;

    assign pc4       = pc + 32'd4;
    assign imem_addr = pc;

    // Region bits come from the jump's own pc plus four
    assign jump_target = {if_id.pc4[31:28], if_id.instr.j.index, 2'b00};

    // Bit 1 selects the branch target and outranks bit 0
    always_comb begin
        if (pc_sel[1]) begin
            pc_next = branch_target;
        end else if (pc_sel[0]) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    ////////////////////
    // IF/ID register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id.pc4   <= '0;
            if_id.instr <= `CPU_NOP_WORD;
        end else if (flush) begin
            if_id.instr <= `CPU_NOP_WORD;
        end else if (!stall) begin
            if_id.pc4   <= pc4;
            if_id.instr <= imem_data;
        end
    end

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::if_id_t    if_id,
    input  logic               id_jump,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_mem_read,
    input  logic               branch_taken,
    output logic               stall,
    output logic               if_flush,
    output logic               ex_flush,
    output logic [1:0]         pc_sel
);

    logic load_use;

    // Load in EX whose result a source field in ID names
    assign load_use = ex_mem_read && (ex_dest != '0) &&
                      (ex_dest == if_id.instr.r.rs || ex_dest == if_id.instr.r.rt);

    always_comb begin
        stall    = 1'b0;
        if_flush = 1'b0;
        ex_flush = 1'b0;
        pc_sel   = 2'b00;
        if (branch_taken) begin
            // Both younger instructions are wrong path
            if_flush = 1'b1;
            ex_flush = 1'b1;
            pc_sel   = 2'b10;
        end else if (load_use) begin
            stall = 1'b1;
        end else if (id_jump) begin
            if_flush = 1'b1;
            pc_sel   = 2'b01;
        end
    end

endmodule

//--- hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  cpu_pkg::word_t   dmem_rdata,
    output cpu_pkg::reg_wr_t wb
);

    cpu_pkg::ex_mem_t mem_wb;
    cpu_pkg::word_t   load_data;

    ////////////////////
    // MEM/WB register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= ex_mem;
        end
    end

    // Sampled in the same cycle the read is on the port
    always_ff @(posedge clk) begin
        load_data <= dmem_rdata;
    end

    assign wb.en   = mem_wb.valid & mem_wb.reg_write;
    assign wb.addr = mem_wb.dest;
    assign wb.data = mem_wb.mem_read ? load_data : mem_wb.result;

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic           clk,
    input  logic           arst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           dmem_we,
    output logic           dmem_re,
    input  cpu_pkg::word_t dmem_rdata
);

    cpu_pkg::if_id_t    if_id;
    cpu_pkg::dec_t      dec;
    logic               id_jump;
    cpu_pkg::word_t     rs_data;
    cpu_pkg::word_t     rt_data;
    cpu_pkg::reg_wr_t   wb;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::reg_addr_t ex_dest;
    logic               ex_mem_read;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;
    logic               stall;
    logic               if_flush;
    logic               ex_flush;
    logic [1:0]         pc_sel;

    // Data port runs straight off EX/MEM
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_re    = ex_mem.mem_read;

    fetch_unit inst_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .flush         (if_flush),
        .pc_sel        (pc_sel),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .if_id         (if_id)
    );

    hazard_unit inst_hazard (
        .if_id        (if_id),
        .id_jump      (id_jump),
        .ex_dest      (ex_dest),
        .ex_mem_read  (ex_mem_read),
        .branch_taken (branch_taken),
        .stall        (stall),
        .if_flush     (if_flush),
        .ex_flush     (ex_flush),
        .pc_sel       (pc_sel)
    );

    instr_decoder inst_decoder (
        .if_id   (if_id),
        .dec     (dec),
        .id_jump (id_jump)
    );

    reg_file inst_gpr (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (dec.rs),
        .rt_addr (dec.rt),
        .wr      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage inst_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .flush         (ex_flush),
        .dec           (dec),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .wb            (wb),
        .ex_mem        (ex_mem),
        .ex_dest       (ex_dest),
        .ex_mem_read   (ex_mem_read),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    writeback_stage inst_writeback (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

endmodule

//--- sim/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
    input logic           clk,
    input logic           arst_n,
    input cpu_pkg::word_t imem_addr,
    input cpu_pkg::word_t dmem_addr,
    input logic           dmem_we,
    input logic           dmem_re
);

    // Count of failed assertions
    int failures = 0;

    // One data access per cycle
    data_port_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(dmem_we && dmem_re))
        else begin
            failures++;
            $error("data port read and write enables are high together");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            failures++;
            $error("fetch address is not word aligned");
        end

    data_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_we || dmem_re) |-> dmem_addr[1:0] == 2'b00)
        else begin
            failures++;
            $error("data address is not word aligned during an access");
        end

    // No store may leak out while reset is held
    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !dmem_we)
        else begin
            failures++;
            $error("data write enable is high during reset");
        end

endmodule

bind cpu_top cpu_properties inst_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re)
);

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int TEST_BUDGET    = 200;
    localparam int RUN_COUNT      = 7;
    localparam int TIMEOUT_CYCLES = RUN_COUNT * (TEST_BUDGET + RESET_CYCLES + 1) + 100;
    localparam cpu_pkg::word_t MARKER_ADDR = 32'h0000_03fc;

    logic           clk = 1'b0;
    logic           arst_n;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_data;
    cpu_pkg::word_t dmem_addr;
    cpu_pkg::word_t dmem_wdata;
    logic           dmem_we;
    logic           dmem_re;
    cpu_pkg::word_t dmem_rdata;

    cpu_pkg::word_t imem [256];
    cpu_pkg::word_t dmem [256];
    int             prog_len;
    logic           marker_hit;
    logic [15:0]    lfsr_state = 16'd48186;
    int             cycle_count = 0;

    always #10 clk = ~clk;

    // Word-addressed memories, read in the same cycle
    assign imem_data  = imem[imem_addr[9:2]];
    // Data only answers while the read enable is up
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : '0;

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            if (dmem_addr == MARKER_ADDR) begin
                marker_hit <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation ran past its limit of %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    // Stop at the first failed port property
    always @(negedge clk) begin
        if (DUT.inst_props.failures != 0) begin
            abort_run("a concurrent assertion on the CPU ports failed");
        end
    end

    cpu_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int width, output cpu_pkg::word_t value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic cpu_pkg::word_t fill_word(input int idx);
        return {8'hc3, idx[7:0], ~idx[7:0], 8'h3c};
    endfunction

    function automatic cpu_pkg::word_t rfmt(input cpu_pkg::funct_e fn, input cpu_pkg::reg_addr_t rd,
                                            input cpu_pkg::reg_addr_t rs,
                                            input cpu_pkg::reg_addr_t rt);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // Assembly order, rt first and then rs
    function automatic cpu_pkg::word_t ifmt(input cpu_pkg::opcode_e op, input cpu_pkg::reg_addr_t rt,
                                            input cpu_pkg::reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_pkg::word_t jfmt(input logic [25:0] word_idx);
        return {cpu_pkg::OP_J, word_idx};
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic start_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `CPU_NOP_WORD;
        end
    endtask

    // End marker is the last store of every program
    task automatic finish_program();
        emit(ifmt(cpu_pkg::OP_ORI, 31, 0, 16'd1));
        emit(ifmt(cpu_pkg::OP_SW, 31, 0, MARKER_ADDR[15:0]));
    endtask

    task automatic clear_data();
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic hold_reset();
        @(negedge clk);
        arst_n     = 1'b0;
        marker_hit <= 1'b0;
        clear_data();
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        assert (imem_addr === `CPU_RESET_PC && dmem_we === 1'b0 && dmem_re === 1'b0) else
            abort_run($sformatf("mismatch at %0t: in reset fetch address %h store %b load %b",
                                $time, imem_addr, dmem_we, dmem_re));
        arst_n = 1'b1;
    endtask

    task automatic wait_for_marker(input string name);
        int cycles;
        cycles = 0;
        while (!marker_hit && cycles < TEST_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        assert (marker_hit) else
            abort_run($sformatf("%s program never stored its end marker in %0d cycles",
                                name, TEST_BUDGET));
    endtask

    task automatic check_word(input int idx, input cpu_pkg::word_t expected, input string what);
        assert (dmem[idx] === expected) else
            abort_run($sformatf("mismatch at %0t: %s, word %0d holds %h, expected %h",
                                $time, what, idx, dmem[idx], expected));
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic alu_forwarding_test();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t e_add;
        cpu_pkg::word_t e_sub;
        cpu_pkg::word_t e_and;
        cpu_pkg::word_t e_or;
        draw_bits(32, a);
        draw_bits(32, b);
        e_add = a + b;
        e_sub = a - e_add;
        e_and = e_sub & e_add;
        e_or  = e_and | a;
        hold_reset();
        start_program();
        emit(ifmt(cpu_pkg::OP_LUI, 1, 0, a[31:16]));
        emit(ifmt(cpu_pkg::OP_ORI, 1, 1, a[15:0]));
        emit(ifmt(cpu_pkg::OP_LUI, 2, 0, b[31:16]));
        emit(ifmt(cpu_pkg::OP_ORI, 2, 2, b[15:0]));
        // Each result feeds the next one directly
        emit(rfmt(cpu_pkg::FN_ADD, 3, 1, 2));
        emit(rfmt(cpu_pkg::FN_SUB, 4, 1, 3));
        emit(rfmt(cpu_pkg::FN_AND, 5, 4, 3));
        emit(rfmt(cpu_pkg::FN_OR, 6, 5, 1));
        emit(rfmt(cpu_pkg::FN_SLT, 7, 6, 4));
        emit(rfmt(cpu_pkg::FN_SLT, 8, 4, 6));
        for (int r = 8; r >= 1; r--) begin
            emit(ifmt(cpu_pkg::OP_SW, r, 0, 16'(4 * (r - 1))));
        end
        finish_program();
        release_reset();
        wait_for_marker("ALU");
        check_word(0, a, "lui and ori operand a");
        check_word(1, b, "lui and ori operand b");
        check_word(2, e_add, "add");
        check_word(3, e_sub, "sub");
        check_word(4, e_and, "and");
        check_word(5, e_or, "or");
        check_word(6, ($signed(e_or) < $signed(e_sub)) ? 32'd1 : 32'd0, "slt");
        check_word(7, ($signed(e_sub) < $signed(e_or)) ? 32'd1 : 32'd0, "slt reversed");
    endtask

    task automatic immediate_test();
        hold_reset();
        start_program();
        emit(ifmt(cpu_pkg::OP_ADDI, 1, 0, 16'h8001));
        emit(ifmt(cpu_pkg::OP_ANDI, 2, 1, 16'h8f0f));
        emit(ifmt(cpu_pkg::OP_ORI, 3, 0, 16'h9234));
        emit(ifmt(cpu_pkg::OP_LUI, 4, 0, 16'ha5c3));
        emit(ifmt(cpu_pkg::OP_ADDI, 5, 4, 16'h7fff));
        emit(ifmt(cpu_pkg::OP_ADDI, 6, 5, 16'hffff));
        emit(ifmt(cpu_pkg::OP_ANDI, 7, 6, 16'hffff));
        for (int r = 1; r <= 7; r++) begin
            emit(ifmt(cpu_pkg::OP_SW, r, 0, 16'(4 * (r - 1))));
        end
        finish_program();
        release_reset();
        wait_for_marker("immediate");
        check_word(0, 32'hffff_8001, "addi sign extension");
        check_word(1, 32'h0000_8001, "andi zero extension");
        check_word(2, 32'h0000_9234, "ori zero extension");
        check_word(3, 32'ha5c3_0000, "lui upper half");
        check_word(4, 32'ha5c3_7fff, "addi positive immediate");
        check_word(5, 32'ha5c3_7ffe, "addi of minus one");
        check_word(6, 32'h0000_7ffe, "andi clears upper half");
    endtask

    task automatic load_use_test();
        cpu_pkg::word_t v;
        cpu_pkg::word_t k;
        draw_bits(32, v);
        draw_bits(16, k);
        hold_reset();
        dmem[8] <= v;
        start_program();
        emit(ifmt(cpu_pkg::OP_ORI, 2, 0, k[15:0]));
        emit(ifmt(cpu_pkg::OP_LW, 1, 0, 16'h0020));
        emit(rfmt(cpu_pkg::FN_ADD, 3, 1, 2));
        emit(ifmt(cpu_pkg::OP_SW, 3, 0, 16'h0000));
        emit(ifmt(cpu_pkg::OP_LW, 4, 0, 16'h0020));
        emit(ifmt(cpu_pkg::OP_SW, 4, 0, 16'h0004));
        // Loaded value used through the rt field
        emit(ifmt(cpu_pkg::OP_LW, 5, 0, 16'h0020));
        emit(rfmt(cpu_pkg::FN_ADD, 6, 2, 5));
        emit(ifmt(cpu_pkg::OP_SW, 6, 0, 16'h0008));
        finish_program();
        release_reset();
        wait_for_marker("load-use");
        check_word(0, v + k, "load then add on rs");
        check_word(1, v, "load then store");
        check_word(2, v + k, "load then add on rt");
    endtask

    task automatic branch_test();
        hold_reset();
        start_program();
        emit(ifmt(cpu_pkg::OP_ORI, 1, 0, 16'd5));
        emit(ifmt(cpu_pkg::OP_ORI, 2, 0, 16'd5));
        emit(ifmt(cpu_pkg::OP_BEQ, 2, 1, 16'd3));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0000));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0004));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0008));
        emit(ifmt(cpu_pkg::OP_SW, 2, 0, 16'h000c));
        emit(ifmt(cpu_pkg::OP_BNE, 2, 1, 16'd2));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0010));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0014));
        finish_program();
        release_reset();
        wait_for_marker("branch");
        // Two flushed, one skipped by the offset
        check_word(0, fill_word(0), "store flushed by taken beq");
        check_word(1, fill_word(1), "second store flushed by taken beq");
        check_word(2, fill_word(2), "store skipped by beq target");
        check_word(3, 32'd5, "store at beq target");
        check_word(4, 32'd5, "first store after untaken bne");
        check_word(5, 32'd5, "second store after untaken bne");
    endtask

    task automatic jump_test();
        hold_reset();
        start_program();
        emit(ifmt(cpu_pkg::OP_ORI, 1, 0, 16'h0077));
        emit(jfmt(26'd3));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0000));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0004));
        emit(jfmt(26'd6));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0008));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h000c));
        finish_program();
        release_reset();
        wait_for_marker("jump");
        check_word(0, fill_word(0), "store after first j");
        check_word(1, 32'h0000_0077, "store at first jump target");
        check_word(2, fill_word(2), "store after second j");
        check_word(3, 32'h0000_0077, "store at second jump target");
    endtask

    task automatic zero_reg_reset_test();
        hold_reset();
        start_program();
        emit(ifmt(cpu_pkg::OP_ADDI, 0, 0, 16'h1234));
        emit(rfmt(cpu_pkg::FN_ADD, 1, 0, 0));
        emit(ifmt(cpu_pkg::OP_ORI, 0, 0, 16'hffff));
        emit(ifmt(cpu_pkg::OP_SW, 0, 0, 16'h0000));
        emit(ifmt(cpu_pkg::OP_SW, 1, 0, 16'h0004));
        emit(ifmt(cpu_pkg::OP_ORI, 2, 0, 16'h00ab));
        emit(ifmt(cpu_pkg::OP_SW, 2, 0, 16'h0008));
        finish_program();
        // Same program twice, the second run after a fresh reset
        for (int run = 0; run < 2; run++) begin
            if (run == 1) begin
                hold_reset();
            end
            release_reset();
            wait_for_marker("register zero");
            check_word(0, 32'd0, "register zero after writes");
            check_word(1, 32'd0, "sum of register zero");
            check_word(2, 32'h0000_00ab, "ori after register zero writes");
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        marker_hit = 1'b0;
        start_program();
        clear_data();
        alu_forwarding_test();
        immediate_test();
        load_use_test();
        branch_test();
        jump_test();
        zero_reg_reset_test();
        @(negedge clk);
        if (DUT.inst_props.failures == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "concurrent assertions failed during the run");
        end
    end

endmodule

//--- tb.f
+incdir+common
common/cpu_pkg.sv
execute/alu.sv
execute/execute_stage.sv
decode/reg_file.sv
decode/instr_decoder.sv
hdl/fetch_unit.sv
hdl/hazard_unit.sv
hdl/writeback_stage.sv
hdl/cpu_top.sv
sim/cpu_properties.sv
sim/cpu_tb.sv
